//--- Bender.yml
package:
  name: mrpnwp_top

sources:
  - target: rtl
    files:
      - src/mem_geom_pkg.sv
      - src/mem_phys_pkg.sv
      - src/sram_if.sv
      - src/live_value_table.sv
      - src/port_ctrl.sv
      - src/group_wrap.sv
      - src/mrpnwp_top.sv

  - target: test
    files:
      - bench/sram_model.sv
      - bench/mrpnwp_chk.sv
      - bench/tb_mrpnwp_top.sv

//--- bench/mrpnwp_chk.sv
`timescale 1ns/10ps
`default_nettype none

module mrpnwp_chk #(
  parameter int SRAM_DELAY = mem_phys_pkg::DEFAULT_SRAM_DELAY
) (
  input logic clk,
  input logic reset,
  input logic ready,
  input logic [mem_geom_pkg::NUM_WR_PORTS-1:0] write,
  input logic [mem_geom_pkg::NUM_RD_PORTS-1:0] read,
  input logic [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_vld,
  input logic [mem_phys_pkg::NUM_GROUPS-1:0] t1_write,
  input logic [mem_phys_pkg::NUM_GROUPS-1:0] t1_read
);
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  int fail_count = 0;

  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !ready && rd_vld == '0 && t1_write == '0 && t1_read == '0)
    else begin
      $error("ready, rd_vld or an SRAM strobe high during reset");
      fail_count++;
    end

  a_ready_holds: assert property (@(posedge clk) disable iff (reset) ready |=> ready)
    else begin
      $error("ready fell after init");
      fail_count++;
    end

  for (genvar r = 0; r < NUM_RD_PORTS; r++) begin : g_port
    // each accepted read returns SRAM_DELAY + 2 edges after its sampling edge
    a_read_returns: assert property (@(posedge clk) disable iff (reset)
      read[r] && ready |=> ##(SRAM_DELAY + 2) rd_vld[r])
      else begin
        $error("accepted read on port %0d got no rd_vld in time", r);
        fail_count++;
      end

    a_vld_has_read: assert property (@(posedge clk) disable iff (reset)
      rd_vld[r] |-> $past(read[r] && ready, SRAM_DELAY + 3))
      else begin
        $error("rd_vld on port %0d without a matching read", r);
        fail_count++;
      end
  end

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_grp
    // group strobes follow accepted requests by one edge
    a_write_strobe: assert property (@(posedge clk) disable iff (reset)
      t1_write[g] == $past(write[g / NUM_RD_PORTS] && ready))
      else begin
        $error("t1_write of group %0d does not follow its write port", g);
        fail_count++;
      end

    a_read_strobe: assert property (@(posedge clk) disable iff (reset)
      t1_read[g] == $past(read[g % NUM_RD_PORTS] && ready))
      else begin
        $error("t1_read of group %0d does not follow its read port", g);
        fail_count++;
      end
  end

endmodule

bind mrpnwp_top mrpnwp_chk #(.SRAM_DELAY(SRAM_DELAY)) u_mrpnwp_chk (
  .clk(clk),
  .reset(reset),
  .ready(ready),
  .write(write),
  .read(read),
  .rd_vld(rd_vld),
  .t1_write(t1_write),
  .t1_read(t1_read)
);

`default_nettype wire

//--- bench/sram_model.sv
`timescale 1ns/10ps
`default_nettype none

module sram_model #(
  parameter int SRAM_DELAY = mem_phys_pkg::DEFAULT_SRAM_DELAY,
  parameter int GROUP = 0
) (
  input logic clk,
  input logic write,
  input mem_phys_pkg::phys_addr_t addr_w,
  input mem_geom_pkg::data_t din,
  input logic read,
  input mem_phys_pkg::phys_addr_t addr_r,
  output mem_geom_pkg::data_t dout
);
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  localparam int DEPTH = 2 ** $bits(phys_addr_t);

  data_t mem [DEPTH];
  // strobe edge plus SRAM_DELAY more
  data_t rd_pipe [SRAM_DELAY + 1];

  // filler that names group and address, so a stray read stands out
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = {12'hbad, 4'(GROUP), 16'(a)};
    end
  end

  // read takes the old word when both ports hit one address
  always @(posedge clk) begin
    if (write) begin
      mem[addr_w] <= din;
    end
    if (read) begin
      rd_pipe[0] <= mem[addr_r];
    end
    for (int i = SRAM_DELAY; i > 0; i--) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[SRAM_DELAY];

endmodule

`default_nettype wire

//--- bench/stim_input.txt
# op port bank row data writer step; bank and row decimal, data hex; t starts a named test
# w writes data; r expects data and writer; step 0 same cycle, 1 next cycle, 2 random gap
t same_port_round_trip
w 0 0 1 11110001 0 2
w 1 1 2 22220002 1 2
r 0 0 1 11110001 0 0
r 1 0 1 11110001 0 2
r 0 1 2 22220002 1 0
r 1 1 2 22220002 1 2
t last_writer_wins
w 0 2 5 aaaa0005 0 1
w 1 2 5 bbbb0005 1 2
r 0 2 5 bbbb0005 1 2
w 0 3 7 cccc0007 0 0
w 1 3 7 dddd0007 1 2
r 1 3 7 dddd0007 1 0
r 0 3 7 dddd0007 1 2
t read_before_write
w 0 0 9 12340009 0 2
i 0 0 0 00000000 0 1
w 1 0 9 56780009 1 0
r 0 0 9 12340009 0 0
r 1 0 9 12340009 0 1
r 0 0 9 56780009 1 0
r 1 0 9 56780009 1 2
t pipelined_reads
w 0 0 3 a0a00003 0 0
w 1 1 3 b1b10013 1 1
w 0 2 3 a2a20023 0 0
w 1 3 3 b3b30033 1 2
r 0 0 3 a0a00003 0 0
r 1 1 3 b1b10013 1 1
r 0 1 3 b1b10013 1 0
r 1 2 3 a2a20023 0 1
r 0 2 3 a2a20023 0 0
r 1 3 3 b3b30033 1 1
r 0 3 3 b3b30033 1 0
r 1 0 3 a0a00003 0 2

//--- bench/tb_mrpnwp_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mrpnwp_top;
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  localparam int SRAM_DELAY = DEFAULT_SRAM_DELAY;
  localparam int RESET_CYCLES = 10;
  localparam int INIT_CYCLES = NUM_BANKS * NUM_ROWS;
  localparam int MAX_GAP = 3;
  localparam int unsigned SEED = 32'h0633_98bf;
  localparam string STIM_FILE = "bench/stim_input.txt";

  logic clk = 1'b0;
  logic reset;
  logic ready;
  logic [NUM_WR_PORTS-1:0] write;
  bank_t [NUM_WR_PORTS-1:0] wr_badr;
  row_t [NUM_WR_PORTS-1:0] wr_radr;
  data_t [NUM_WR_PORTS-1:0] din;
  logic [NUM_RD_PORTS-1:0] read;
  bank_t [NUM_RD_PORTS-1:0] rd_badr;
  row_t [NUM_RD_PORTS-1:0] rd_radr;
  logic [NUM_RD_PORTS-1:0] rd_vld;
  data_t [NUM_RD_PORTS-1:0] rd_dout;
  padr_t [NUM_RD_PORTS-1:0] rd_padr;
  logic [NUM_GROUPS-1:0] t1_write;
  phys_addr_t [NUM_GROUPS-1:0] t1_addr_w;
  data_t [NUM_GROUPS-1:0] t1_din;
  logic [NUM_GROUPS-1:0] t1_read;
  phys_addr_t [NUM_GROUPS-1:0] t1_addr_r;
  data_t [NUM_GROUPS-1:0] t1_dout;

  int cycle = 0;
  int checks = 0;
  int errors = 0;
  int tests = 0;
  int test_checks = 0;
  int test_errors = 0;
  int limit_cycles = 0;
  string cur_test = "";
  string lines [$];

  // expected results per read port in issue order
  data_t exp_data [NUM_RD_PORTS][$];
  padr_t exp_padr [NUM_RD_PORTS][$];
  int exp_cycle [NUM_RD_PORTS][$];

  mrpnwp_top #(.SRAM_DELAY(SRAM_DELAY)) u_mrpnwp_top (.*);

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_sram
    sram_model #(.SRAM_DELAY(SRAM_DELAY), .GROUP(g)) u_sram (
      .clk(clk),
      .write(t1_write[g]),
      .addr_w(t1_addr_w[g]),
      .din(t1_din[g]),
      .read(t1_read[g]),
      .addr_r(t1_addr_r[g]),
      .dout(t1_dout[g])
    );
  end

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic idle_inputs();
    write = '0;
    wr_badr = '0;
    wr_radr = '0;
    din = '0;
    read = '0;
    rd_badr = '0;
    rd_radr = '0;
  endtask

  task automatic tally_check();
    checks++;
    test_checks++;
  endtask

  task automatic record_error();
    errors++;
    test_errors++;
  endtask

  function automatic int pending_reads();
    int n;
    n = 0;
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      n += exp_data[r].size();
    end
    return n;
  endfunction

  task automatic check_read(input int r);
    data_t want_data;
    padr_t want_padr;
    int want_cycle;
    if (exp_data[r].size() == 0) begin
      $display("rd_vld on port %0d at cycle %0d with no read outstanding", r, cycle);
      record_error();
    end else begin
      want_data = exp_data[r].pop_front();
      want_padr = exp_padr[r].pop_front();
      want_cycle = exp_cycle[r].pop_front();
      tally_check();
      assert (rd_dout[r] === want_data) else begin
        $display("[FAIL] rd_dout[%0d] got %h expected %h", r, rd_dout[r], want_data);
        record_error();
      end
      assert (rd_padr[r] === want_padr) else begin
        $display("[FAIL] rd_padr[%0d] got %h expected %h", r, rd_padr[r], want_padr);
        record_error();
      end
      assert (cycle == want_cycle) else begin
        $display("read on port %0d came back at cycle %0d instead of %0d",
          r, cycle, want_cycle);
        record_error();
      end
    end
  endtask

  // outputs are stable by the falling edge
  always @(negedge clk) begin
    if (reset === 1'b0) begin
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        if (rd_vld[r] === 1'b1) begin
          check_read(r);
        end
      end
    end
  end

  task automatic end_test();
    while (pending_reads() > 0) begin
      @(negedge clk);
    end
    tests++;
    $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    cur_test = "";
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic load_stim();
    int fd;
    string line;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic reset_and_init();
    int waited;
    cur_test = "ready_after_init";
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      tally_check();
      assert (ready === 1'b0) else begin
        $display("[FAIL] ready got %h expected 0 during reset", ready);
        record_error();
      end
    end
    reset = 1'b0;
    waited = 0;
    while (ready !== 1'b1) begin
      @(negedge clk);
      waited++;
    end
    tally_check();
    assert (waited == INIT_CYCLES) else begin
      $display("ready rose %0d cycles after reset instead of %0d", waited, INIT_CYCLES);
      record_error();
    end
    end_test();
  endtask

  // step 0 keeps the cycle for the next line and step 2 adds a random idle gap
  task automatic apply_line(input string line);
    string op;
    string name;
    int fields;
    int port;
    int bank;
    int row;
    int writer;
    int step;
    data_t data;
    int unsigned gap;
    op = "";
    fields = $sscanf(line, "%s", op);
    if (fields >= 1 && op.substr(0, 0) != "#") begin
      if (op == "t") begin
        void'($sscanf(line, "%s %s", op, name));
        if (cur_test != "") begin
          end_test();
        end
        cur_test = name;
      end else begin
        fields = $sscanf(line, "%s %d %d %d %h %d %d",
          op, port, bank, row, data, writer, step);
        if (fields != 7 || port < 0 || port >= NUM_RD_PORTS || port >= NUM_WR_PORTS) begin
          $display("malformed stimulus line: %s", line);
          record_error();
        end else begin
          if (op == "w") begin
            write[port] = 1'b1;
            wr_badr[port] = bank_t'(bank);
            wr_radr[port] = row_t'(row);
            din[port] = data;
          end else if (op == "r") begin
            read[port] = 1'b1;
            rd_badr[port] = bank_t'(bank);
            rd_radr[port] = row_t'(row);
            exp_data[port].push_back(data);
            exp_padr[port].push_back({wport_t'(writer), bank_t'(bank), row_t'(row)});
            // rd_vld lands SRAM_DELAY + 2 edges after the sampling edge
            exp_cycle[port].push_back(cycle + SRAM_DELAY + 3);
          end
          if (step > 0) begin
            @(negedge clk);
            idle_inputs();
            if (step > 1) begin
              gap = $urandom % (MAX_GAP + 1);
              repeat (gap) @(negedge clk);
            end
          end
        end
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    reset = 1'b1;
    idle_inputs();
    load_stim();
    if (lines.size() == 0) begin
      $display("no stimulus could be read from %s", STIM_FILE);
      record_error();
    end else begin
      limit_cycles = RESET_CYCLES + INIT_CYCLES
        + (lines.size() + 1) * (MAX_GAP + SRAM_DELAY + 4);
      reset_and_init();
      foreach (lines[i]) begin
        apply_line(lines[i]);
      end
      end_test();
      // catch any late or extra rd_vld
      repeat (SRAM_DELAY + 4) @(negedge clk);
    end
    errors += u_mrpnwp_top.u_mrpnwp_chk.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- mrpnwp_top.f
src/mem_geom_pkg.sv
src/mem_phys_pkg.sv
src/sram_if.sv
src/live_value_table.sv
src/port_ctrl.sv
src/group_wrap.sv
src/mrpnwp_top.sv
bench/sram_model.sv
bench/mrpnwp_chk.sv
bench/tb_mrpnwp_top.sv

//--- src/group_wrap.sv
`timescale 1ns/10ps
`default_nettype none

module group_wrap (
  input logic [mem_geom_pkg::NUM_WR_PORTS-1:0] req_write,
  input mem_phys_pkg::phys_addr_t [mem_geom_pkg::NUM_WR_PORTS-1:0] req_waddr,
  input mem_geom_pkg::data_t [mem_geom_pkg::NUM_WR_PORTS-1:0] req_din,
  input logic [mem_geom_pkg::NUM_RD_PORTS-1:0] req_read,
  input mem_phys_pkg::phys_addr_t [mem_geom_pkg::NUM_RD_PORTS-1:0] req_raddr,
  output mem_geom_pkg::data_t [mem_phys_pkg::NUM_GROUPS-1:0] grp_dout,
  sram_if.ctrl grp [mem_phys_pkg::NUM_GROUPS]
);
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  // group g pairs write port g / NUM_RD_PORTS with read port g % NUM_RD_PORTS
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_grp
    localparam int WP = g / NUM_RD_PORTS;
    localparam int RP = g % NUM_RD_PORTS;

    // each write port lands in one group per read port
    assign grp[g].write = req_write[WP];
    assign grp[g].waddr = req_waddr[WP];
    assign grp[g].wdata = req_din[WP];

    // each read port reads one group per write port
    assign grp[g].read = req_read[RP];
    assign grp[g].raddr = req_raddr[RP];

    assign grp_dout[g] = grp[g].rdata;
  end

endmodule

`default_nettype wire

//--- src/live_value_table.sv
`timescale 1ns/10ps
`default_nettype none

module live_value_table (
  input logic clk,
  input logic reset,
  input mem_geom_pkg::bank_t [mem_geom_pkg::NUM_RD_PORTS-1:0] lookup_bank,
  input mem_geom_pkg::row_t [mem_geom_pkg::NUM_RD_PORTS-1:0] lookup_row,
  output mem_geom_pkg::wport_t [mem_geom_pkg::NUM_RD_PORTS-1:0] lookup_writer,
  input logic [mem_geom_pkg::NUM_WR_PORTS-1:0] upd_en,
  input mem_geom_pkg::bank_t [mem_geom_pkg::NUM_WR_PORTS-1:0] upd_bank,
  input mem_geom_pkg::row_t [mem_geom_pkg::NUM_WR_PORTS-1:0] upd_row,
  output logic ready
);
  import mem_geom_pkg::*;

  localparam int NUM_ENTRIES = NUM_BANKS * NUM_ROWS;
  localparam int CNT_BITS = $clog2(NUM_ENTRIES);

  wport_t lvt_mem [NUM_BANKS][NUM_ROWS];

  logic [CNT_BITS-1:0] clr_cnt;
  bank_t clr_bank;
  row_t clr_row;

  assign {clr_bank, clr_row} = clr_cnt;

  // walk every entry once after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      clr_cnt <= '0;
      ready <= 1'b0;
    end else if (!ready) begin
      clr_cnt <= clr_cnt + 1'b1;
      if (clr_cnt == CNT_BITS'(NUM_ENTRIES - 1)) begin
        ready <= 1'b1;
      end
    end
  end

  // later loop iteration wins, so the higher port takes a shared entry
  always_ff @(posedge clk) begin
    if (!ready) begin
      lvt_mem[clr_bank][clr_row] <= '0;
    end else begin
      for (int w = 0; w < NUM_WR_PORTS; w++) begin
        if (upd_en[w]) begin
          lvt_mem[upd_bank[w]][upd_row[w]] <= wport_t'(w);
        end
      end
    end
  end

  // lookup sees the table before this cycle's updates
  always_comb begin
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      lookup_writer[r] = lvt_mem[lookup_bank[r]][lookup_row[r]];
    end
  end

endmodule

`default_nettype wire

//--- src/mem_geom_pkg.sv
`default_nettype none

package mem_geom_pkg;

  // logical port counts
  localparam int NUM_WR_PORTS = 2;
  localparam int NUM_RD_PORTS = 2;

  // virtual banks and rows per bank
  localparam int NUM_BANKS = 4;
  localparam int NUM_ROWS = 16;

  localparam int DATA_WIDTH = 32;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int ROW_BITS = $clog2(NUM_ROWS);
  localparam int WPORT_BITS = $clog2(NUM_WR_PORTS);

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BANK_BITS-1:0] bank_t;
  typedef logic [ROW_BITS-1:0] row_t;

  // write port index, also what the live value table stores
  typedef logic [WPORT_BITS-1:0] wport_t;

endpackage

`default_nettype wire

//--- src/mem_phys_pkg.sv
`default_nettype none

package mem_phys_pkg;

  // one SRAM per write port and read port pair
  localparam int NUM_GROUPS = mem_geom_pkg::NUM_WR_PORTS * mem_geom_pkg::NUM_RD_PORTS;

  // bank above row
  localparam int PHYS_ADDR_BITS = mem_geom_pkg::BANK_BITS + mem_geom_pkg::ROW_BITS;

  // writer above bank above row
  localparam int PADR_BITS = mem_geom_pkg::WPORT_BITS + PHYS_ADDR_BITS;

  typedef logic [PHYS_ADDR_BITS-1:0] phys_addr_t;
  typedef logic [PADR_BITS-1:0] padr_t;

  // edges from read strobe to read data at the SRAM
  localparam int DEFAULT_SRAM_DELAY = 2;

endpackage

`default_nettype wire

//--- src/mrpnwp_top.sv
`timescale 1ns/10ps
`default_nettype none

module mrpnwp_top #(
  parameter int SRAM_DELAY = mem_phys_pkg::DEFAULT_SRAM_DELAY
) (
  input logic clk,
  input logic reset,
  output logic ready,

  input logic [mem_geom_pkg::NUM_WR_PORTS-1:0] write,
  input mem_geom_pkg::bank_t [mem_geom_pkg::NUM_WR_PORTS-1:0] wr_badr,
  input mem_geom_pkg::row_t [mem_geom_pkg::NUM_WR_PORTS-1:0] wr_radr,
  input mem_geom_pkg::data_t [mem_geom_pkg::NUM_WR_PORTS-1:0] din,

  input logic [mem_geom_pkg::NUM_RD_PORTS-1:0] read,
  input mem_geom_pkg::bank_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_badr,
  input mem_geom_pkg::row_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_radr,
  output logic [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_vld,
  output mem_geom_pkg::data_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_dout,
  output mem_phys_pkg::padr_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_padr,

  // external SRAMs, one per group
  output logic [mem_phys_pkg::NUM_GROUPS-1:0] t1_write,
  output mem_phys_pkg::phys_addr_t [mem_phys_pkg::NUM_GROUPS-1:0] t1_addr_w,
  output mem_geom_pkg::data_t [mem_phys_pkg::NUM_GROUPS-1:0] t1_din,
  output logic [mem_phys_pkg::NUM_GROUPS-1:0] t1_read,
  output mem_phys_pkg::phys_addr_t [mem_phys_pkg::NUM_GROUPS-1:0] t1_addr_r,
  input mem_geom_pkg::data_t [mem_phys_pkg::NUM_GROUPS-1:0] t1_dout
);
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  logic [NUM_WR_PORTS-1:0] req_write;
  phys_addr_t [NUM_WR_PORTS-1:0] req_waddr;
  data_t [NUM_WR_PORTS-1:0] req_din;
  logic [NUM_RD_PORTS-1:0] req_read;
  phys_addr_t [NUM_RD_PORTS-1:0] req_raddr;
  data_t [NUM_GROUPS-1:0] grp_dout;

  sram_if grp_if [NUM_GROUPS] ();

  port_ctrl #(
    .SRAM_DELAY(SRAM_DELAY)
  ) u_port_ctrl (
    .clk(clk),
    .reset(reset),
    .write(write),
    .wr_badr(wr_badr),
    .wr_radr(wr_radr),
    .din(din),
    .read(read),
    .rd_badr(rd_badr),
    .rd_radr(rd_radr),
    .ready(ready),
    .rd_vld(rd_vld),
    .rd_dout(rd_dout),
    .rd_padr(rd_padr),
    .req_write(req_write),
    .req_waddr(req_waddr),
    .req_din(req_din),
    .req_read(req_read),
    .req_raddr(req_raddr),
    .grp_dout(grp_dout)
  );

  group_wrap u_group_wrap (
    .req_write(req_write),
    .req_waddr(req_waddr),
    .req_din(req_din),
    .req_read(req_read),
    .req_raddr(req_raddr),
    .grp_dout(grp_dout),
    .grp(grp_if)
  );

  // group interfaces out to the flat SRAM pins
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_t1
    assign t1_write[g] = grp_if[g].write;
    assign t1_addr_w[g] = grp_if[g].waddr;
    assign t1_din[g] = grp_if[g].wdata;
    assign t1_read[g] = grp_if[g].read;
    assign t1_addr_r[g] = grp_if[g].raddr;
    assign grp_if[g].rdata = t1_dout[g];
  end

endmodule

`default_nettype wire

//--- src/port_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module port_ctrl #(
  parameter int SRAM_DELAY = mem_phys_pkg::DEFAULT_SRAM_DELAY
) (
  input logic clk,
  input logic reset,
  input logic [mem_geom_pkg::NUM_WR_PORTS-1:0] write,
  input mem_geom_pkg::bank_t [mem_geom_pkg::NUM_WR_PORTS-1:0] wr_badr,
  input mem_geom_pkg::row_t [mem_geom_pkg::NUM_WR_PORTS-1:0] wr_radr,
  input mem_geom_pkg::data_t [mem_geom_pkg::NUM_WR_PORTS-1:0] din,
  input logic [mem_geom_pkg::NUM_RD_PORTS-1:0] read,
  input mem_geom_pkg::bank_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_badr,
  input mem_geom_pkg::row_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_radr,
  output logic ready,
  output logic [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_vld,
  output mem_geom_pkg::data_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_dout,
  output mem_phys_pkg::padr_t [mem_geom_pkg::NUM_RD_PORTS-1:0] rd_padr,
  output logic [mem_geom_pkg::NUM_WR_PORTS-1:0] req_write,
  output mem_phys_pkg::phys_addr_t [mem_geom_pkg::NUM_WR_PORTS-1:0] req_waddr,
  output mem_geom_pkg::data_t [mem_geom_pkg::NUM_WR_PORTS-1:0] req_din,
  output logic [mem_geom_pkg::NUM_RD_PORTS-1:0] req_read,
  output mem_phys_pkg::phys_addr_t [mem_geom_pkg::NUM_RD_PORTS-1:0] req_raddr,
  input mem_geom_pkg::data_t [mem_phys_pkg::NUM_GROUPS-1:0] grp_dout
);
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  localparam int GSEL_BITS = $clog2(NUM_GROUPS);
  localparam int WRITER_LSB = $bits(padr_t) - $bits(wport_t);

  bank_t [NUM_WR_PORTS-1:0] wbank_q;
  row_t [NUM_WR_PORTS-1:0] wrow_q;
  bank_t [NUM_RD_PORTS-1:0] rbank_q;
  row_t [NUM_RD_PORTS-1:0] rrow_q;
  wport_t [NUM_RD_PORTS-1:0] rd_writer;

  // read context, stage 0 loads on the edge the SRAM takes the strobe
  logic [SRAM_DELAY:0] ctx_vld [NUM_RD_PORTS];
  padr_t [SRAM_DELAY:0] ctx_padr [NUM_RD_PORTS];
  logic [GSEL_BITS-1:0] grp_sel [NUM_RD_PORTS];

  // request strobes, dropped until the table is cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      req_write <= '0;
      req_read <= '0;
    end else begin
      req_write <= write & {NUM_WR_PORTS{ready}};
      req_read <= read & {NUM_RD_PORTS{ready}};
    end
  end

  always_ff @(posedge clk) begin
    wbank_q <= wr_badr;
    wrow_q <= wr_radr;
    req_din <= din;
    rbank_q <= rd_badr;
    rrow_q <= rd_radr;
  end

  always_comb begin
    for (int w = 0; w < NUM_WR_PORTS; w++) begin
      req_waddr[w] = {wbank_q[w], wrow_q[w]};
    end
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      req_raddr[r] = {rbank_q[r], rrow_q[r]};
    end
  end

  // table update lands on the same edge as the SRAM write
  live_value_table u_lvt (
    .clk(clk),
    .reset(reset),
    .lookup_bank(rbank_q),
    .lookup_row(rrow_q),
    .lookup_writer(rd_writer),
    .upd_en(req_write),
    .upd_bank(wbank_q),
    .upd_row(wrow_q),
    .ready(ready)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        ctx_vld[r] <= '0;
      end
    end else begin
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        for (int i = SRAM_DELAY; i > 0; i--) begin
          ctx_vld[r][i] <= ctx_vld[r][i-1];
        end
        ctx_vld[r][0] <= req_read[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      for (int i = SRAM_DELAY; i > 0; i--) begin
        ctx_padr[r][i] <= ctx_padr[r][i-1];
      end
      ctx_padr[r][0] <= {rd_writer[r], rbank_q[r], rrow_q[r]};
    end
  end

  // group of the last writer paired with this read port
  always_comb begin
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      grp_sel[r] = GSEL_BITS'(
        ctx_padr[r][SRAM_DELAY][WRITER_LSB +: $bits(wport_t)] * NUM_RD_PORTS + r);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= '0;
    end else begin
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        rd_vld[r] <= ctx_vld[r][SRAM_DELAY];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      rd_dout[r] <= grp_dout[grp_sel[r]];
      rd_padr[r] <= ctx_padr[r][SRAM_DELAY];
    end
  end

endmodule

`default_nettype wire

//--- src/sram_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sram_if;
  import mem_geom_pkg::*;
  import mem_phys_pkg::*;

  // write side
  logic write;
  phys_addr_t waddr;
  data_t wdata;

  // read side
  logic read;
  phys_addr_t raddr;
  data_t rdata;

  modport ctrl (
    output write,
    output waddr,
    output wdata,
    output read,
    output raddr,
    input rdata
  );

  modport mem (
    input write,
    input waddr,
    input wdata,
    input read,
    input raddr,
    output rdata
  );

endinterface

`default_nettype wire
